// ==== compile.f ====
+incdir+.
mih_pkg.sv
matrix_header_parser.sv
empty_slot_finder.sv
element_streamer.sv
input_sequencer.sv
matrix_input_handler.sv
storage_manager_model.sv
matrix_input_handler_tb.sv

// ==== element_streamer.sv ====
`default_nettype none

module element_streamer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stream_start,
    input  mih_pkg::buf_addr_t     first_addr,
    input  mih_pkg::elem_count_t   total,
    input  mih_pkg::buf_addr_t     num_count,
    input  mih_pkg::data_word_t    buf_rd_data,
    output mih_pkg::buf_addr_t     buf_rd_addr,
    input  logic                   writer_ready,
    input  mih_pkg::mih_settings_t settings,
    output mih_pkg::data_word_t    data_in,
    output logic                   data_valid,
    output logic                   stream_end,
    output logic                   range_fail
);
    import mih_pkg::*;

    logic        fetch;     // Address on the bus this cycle
    logic        pend;      // RAM data returns this cycle
    logic        held;      // Element waiting for the writer
    buf_addr_t   ptr;
    elem_count_t sent;
    data_word_t  elem;
    logic        in_range;
    logic        take;

    assign buf_rd_addr = ptr;
    assign data_in     = elem;
    assign in_range    = ($signed(elem) >= $signed(settings.data_min)) &&
                         ($signed(elem) <= $signed(settings.data_max));
    assign take        = held && writer_ready;
    assign data_valid  = take && in_range;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch      <= 1'b0;
            pend       <= 1'b0;
            held       <= 1'b0;
            ptr        <= '0;
            sent       <= '0;
            stream_end <= 1'b0;
            range_fail <= 1'b0;
        end else begin
            stream_end <= 1'b0;
            range_fail <= 1'b0;
            if (stream_start) begin
                ptr   <= first_addr;
                sent  <= '0;
                fetch <= 1'b1;
                pend  <= 1'b0;
                held  <= 1'b0;
            end else begin
                fetch <= 1'b0;
                pend  <= fetch;
                if (pend) held <= 1'b1;
                if (take) begin
                    held <= 1'b0;
                    if (!in_range) begin
                        range_fail <= 1'b1;   // Stream stops here
                    end else begin
                        sent <= sent + 1'b1;
                        if (sent + 1'b1 == total) begin
                            stream_end <= 1'b1;
                        end else begin
                            ptr   <= ptr + 1'b1;
                            fetch <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // Past the fill count the buffer holds nothing valid
    always_ff @(posedge clk) begin
        if (pend) begin
            elem <= (ptr < num_count) ? buf_rd_data : '0;
        end
    end

endmodule

`default_nettype wire

// ==== empty_slot_finder.sv ====
`default_nettype none
`include "mih_params.svh"

module empty_slot_finder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   find_start,
    input  mih_pkg::data_word_t    storage_rd_data,
    output mih_pkg::storage_addr_t storage_rd_addr,
    output mih_pkg::matrix_id_t    slot_id,
    output logic                   slot_found,
    output logic                   slot_none
);
    import mih_pkg::*;

    logic       active;
    logic       check;          // Low on the address cycle, high when data returns
    matrix_id_t slot;
    logic       slot_empty;

    assign storage_rd_addr = storage_addr_t'(slot * `MIH_SLOT_STRIDE);
    assign slot_empty      = (storage_rd_data[`MIH_OCC_HI:`MIH_OCC_LO] == '0);
    assign slot_id         = slot;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active     <= 1'b0;
            check      <= 1'b0;
            slot       <= '0;
            slot_found <= 1'b0;
            slot_none  <= 1'b0;
        end else begin
            slot_found <= 1'b0;
            slot_none  <= 1'b0;
            if (find_start) begin
                active <= 1'b1;
                check  <= 1'b0;
                slot   <= matrix_id_t'(1);   // Slot 0 is never handed out
            end else if (active) begin
                if (!check) begin
                    check <= 1'b1;
                end else if (slot_empty) begin
                    active     <= 1'b0;
                    slot_found <= 1'b1;
                end else if (slot == matrix_id_t'(`MIH_MAX_ID)) begin
                    active    <= 1'b0;
                    slot_none <= 1'b1;
                end else begin
                    slot  <= slot + 1'b1;
                    check <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== input_sequencer.sv ====
`default_nettype none

module input_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic header_ok,
    input  logic header_bad,
    input  logic header_named,
    input  logic slot_found,
    input  logic slot_none,
    input  logic stream_end,
    input  logic range_fail,
    input  logic write_ready,
    input  logic writer_ready,
    input  logic write_done,
    input  logic clear_done,
    output logic parse_start,
    output logic find_start,
    output logic stream_start,
    output logic stream_phase,
    output logic write_request,
    output logic clear_request,
    output logic busy,
    output logic done,
    output logic error
);
    import mih_pkg::*;

    seq_state_t state;
    logic       writer_go;

    // Writer has taken the request and is ready for data
    assign writer_go = writer_ready && !write_ready;

    assign parse_start   = (state == S_IDLE) && start;
    assign find_start    = (state == S_PARSE) && header_ok && !header_named;
    assign write_request = (state == S_WREQ) && write_ready;
    assign stream_start  = (state == S_WRDY) && writer_go;
    assign stream_phase  = (state == S_STREAM);
    assign clear_request = (state == S_CLEAR);     // Single cycle state
    assign busy          = (state != S_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            done  <= 1'b0;
            error <= 1'b0;
        end else begin
            done  <= 1'b0;
            error <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) state <= S_PARSE;
                end
                S_PARSE: begin
                    if (header_bad) begin
                        error <= 1'b1;
                        state <= S_IDLE;
                    end else if (header_ok) begin
                        state <= header_named ? S_WREQ : S_FIND;
                    end
                end
                S_FIND: begin
                    if (slot_none) begin
                        error <= 1'b1;   // Storage full
                        state <= S_IDLE;
                    end else if (slot_found) begin
                        state <= S_WREQ;
                    end
                end
                S_WREQ: begin
                    if (write_ready) state <= S_WRDY;
                end
                S_WRDY: begin
                    if (writer_go) state <= S_STREAM;
                end
                S_STREAM: begin
                    if (range_fail) begin
                        state <= S_CLEAR;
                    end else if (stream_end) begin
                        state <= S_WDONE;
                    end
                end
                S_WDONE: begin
                    if (write_done) begin
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                S_CLEAR: state <= S_CLWAIT;
                S_CLWAIT: begin
                    if (clear_done) begin
                        error <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== matrix_header_parser.sv ====
`default_nettype none
`include "mih_params.svh"

module matrix_header_parser (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    parse_start,
    input  mih_pkg::data_word_t     buf_rd_data,
    output mih_pkg::buf_addr_t      buf_rd_addr,
    input  mih_pkg::mih_settings_t  settings,
    output mih_pkg::matrix_header_t header,
    output mih_pkg::buf_addr_t      next_addr,
    output logic                    header_ok,
    output logic                    header_bad
);
    import mih_pkg::*;

    parser_state_t state;
    parser_state_t after_wait;   // Word decoded once the address settles
    buf_addr_t     ptr;
    logic [3:0]    name_cnt;
    logic          is_marker;
    logic          id_bad;
    logic          dim_bad;

    assign buf_rd_addr = ptr;
    assign is_marker   = (buf_rd_data == `MIH_NAMED_MARKER);
    assign id_bad      = (buf_rd_data < 1) || (buf_rd_data > `MIH_MAX_ID);

    // Rows come from the register, cols straight off the bus
    assign dim_bad = (header.rows == '0) || (32'(header.rows) > settings.max_row) ||
                     (buf_rd_data == '0) || ($unsigned(buf_rd_data) > settings.max_col);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= P_IDLE;
            after_wait <= P_IDLE;
            ptr        <= '0;
            name_cnt   <= '0;
            header_ok  <= 1'b0;
            header_bad <= 1'b0;
        end else begin
            header_ok  <= 1'b0;
            header_bad <= 1'b0;
            case (state)
                P_IDLE: begin
                    if (parse_start) begin
                        state <= P_MARK;   // Word 0 already addressed
                    end
                end
                P_MARK: begin
                    ptr        <= ptr + 1'b1;
                    state      <= P_WAIT;
                    after_wait <= is_marker ? P_ID : P_COLS;
                end
                P_WAIT: state <= after_wait;
                P_ID: begin
                    if (id_bad) begin
                        header_bad <= 1'b1;
                        ptr        <= '0;
                        state      <= P_IDLE;
                    end else begin
                        ptr        <= ptr + 1'b1;
                        name_cnt   <= '0;
                        after_wait <= P_NAME;
                        state      <= P_WAIT;
                    end
                end
                P_NAME: begin
                    ptr      <= ptr + 1'b1;
                    name_cnt <= name_cnt + 1'b1;
                    state    <= P_WAIT;
                    if (name_cnt == 4'(`MIH_NAME_WORDS - 1)) begin
                        after_wait <= P_ROWS;
                    end else begin
                        after_wait <= P_NAME;
                    end
                end
                P_ROWS: begin
                    ptr        <= ptr + 1'b1;
                    after_wait <= P_COLS;
                    state      <= P_WAIT;
                end
                P_COLS: begin
                    ptr        <= '0;
                    state      <= P_IDLE;
                    header_ok  <= !dim_bad;
                    header_bad <= dim_bad;
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == P_IDLE && parse_start) begin
            header.named <= 1'b0;
            header.id    <= '0;     // Anonymous ID is filled in later
            header.name  <= '0;
        end
        if (state == P_MARK) begin
            header.named <= is_marker;
            if (!is_marker) begin
                header.rows <= buf_rd_data[7:0];
            end
        end
        if (state == P_ID) header.id <= buf_rd_data[2:0];
        if (state == P_NAME) begin
            header.name <= matrix_name_t'({header.name, buf_rd_data});  // Shift in from the bottom
        end
        if (state == P_ROWS) header.rows <= buf_rd_data[7:0];
        if (state == P_COLS) begin
            header.cols <= buf_rd_data[7:0];
            next_addr   <= ptr + 1'b1;   // First element
        end
    end

endmodule

`default_nettype wire

// ==== matrix_input_handler.sv ====
`default_nettype none

module matrix_input_handler (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    output logic                    busy,
    output logic                    done,
    output logic                    error,
    input  mih_pkg::mih_settings_t  settings,
    output mih_pkg::buf_addr_t      buf_rd_addr,
    input  mih_pkg::data_word_t     buf_rd_data,
    input  mih_pkg::buf_addr_t      num_count,
    output mih_pkg::storage_addr_t  storage_rd_addr,
    input  mih_pkg::data_word_t     storage_rd_data,
    output logic                    write_request,
    input  logic                    write_ready,
    input  logic                    writer_ready,
    input  logic                    write_done,
    output mih_pkg::matrix_header_t header,
    output mih_pkg::data_word_t     data_in,
    output logic                    data_valid,
    output logic                    clear_request,
    output mih_pkg::matrix_id_t     clear_matrix_id,
    input  logic                    clear_done
);
    import mih_pkg::*;

    matrix_header_t p_header;
    buf_addr_t      next_addr, p_buf_addr, s_buf_addr;
    matrix_id_t     slot_id, id_q;
    elem_count_t    elem_total;
    logic           header_ok, header_bad, slot_found, slot_none;
    logic           parse_start, find_start, stream_start, stream_phase;
    logic           stream_end, range_fail;

    // Anonymous records take the slot picked by the finder
    always_ff @(posedge clk) begin
        if (header_ok) begin
            id_q <= p_header.id;
        end else if (slot_found) begin
            id_q <= slot_id;
        end
    end

    always_comb begin
        header    = p_header;
        header.id = id_q;
    end

    assign clear_matrix_id = id_q;
    assign elem_total      = elem_count_t'(p_header.rows) * elem_count_t'(p_header.cols);
    assign buf_rd_addr     = stream_phase ? s_buf_addr : p_buf_addr;

    matrix_header_parser u_parser (
        .clk(clk), .rst_n(rst_n), .parse_start(parse_start),
        .buf_rd_data(buf_rd_data), .buf_rd_addr(p_buf_addr), .settings(settings),
        .header(p_header), .next_addr(next_addr),
        .header_ok(header_ok), .header_bad(header_bad)
    );

    empty_slot_finder u_finder (
        .clk(clk), .rst_n(rst_n), .find_start(find_start),
        .storage_rd_data(storage_rd_data), .storage_rd_addr(storage_rd_addr),
        .slot_id(slot_id), .slot_found(slot_found), .slot_none(slot_none)
    );

    element_streamer u_streamer (
        .clk(clk), .rst_n(rst_n), .stream_start(stream_start),
        .first_addr(next_addr), .total(elem_total), .num_count(num_count),
        .buf_rd_data(buf_rd_data), .buf_rd_addr(s_buf_addr),
        .writer_ready(writer_ready), .settings(settings),
        .data_in(data_in), .data_valid(data_valid),
        .stream_end(stream_end), .range_fail(range_fail)
    );

    input_sequencer u_seq (
        .clk(clk), .rst_n(rst_n), .start(start),
        .header_ok(header_ok), .header_bad(header_bad), .header_named(p_header.named),
        .slot_found(slot_found), .slot_none(slot_none),
        .stream_end(stream_end), .range_fail(range_fail),
        .write_ready(write_ready), .writer_ready(writer_ready),
        .write_done(write_done), .clear_done(clear_done),
        .parse_start(parse_start), .find_start(find_start),
        .stream_start(stream_start), .stream_phase(stream_phase),
        .write_request(write_request), .clear_request(clear_request),
        .busy(busy), .done(done), .error(error)
    );

endmodule

`default_nettype wire

// ==== matrix_input_handler_tb.sv ====
`default_nettype none
`include "mih_params.svh"

module matrix_input_handler_tb;
    import mih_pkg::*;

    logic           clk, rst_n, start, busy, done, error;
    mih_settings_t  settings;
    buf_addr_t      buf_rd_addr, num_count;
    data_word_t     buf_rd_data, storage_rd_data, data_in;
    storage_addr_t  storage_rd_addr;
    logic           write_request, write_ready, writer_ready, write_done;
    logic           data_valid, clear_request, clear_done;
    matrix_header_t header;
    matrix_id_t     clear_matrix_id;
    logic [7:0]     occupied;

    data_word_t     buf_mem [0:2047];
    data_word_t     exp_elems [0:255];
    logic           exp_error, exp_write, exp_clear, exp_named;
    matrix_id_t     exp_id;
    dim_t           exp_rows, exp_cols;
    matrix_name_t   exp_name;
    int             exp_n, done_cnt, err_cnt, test_errs, tests_run, tests_failed;

    matrix_input_handler UUT (.*);
    storage_manager_model storage (.*);

    always #4 clk = ~clk;

    always @(posedge clk) buf_rd_data <= #1 buf_mem[buf_rd_addr];   // One cycle read latency

    always @(posedge clk) begin
        if (!rst_n) begin
            done_cnt <= 0;
            err_cnt  <= 0;
        end else begin
            if (done) done_cnt <= done_cnt + 1;
            if (error) err_cnt <= err_cnt + 1;
        end
    end

    // Expected outcome of the record now in the buffer
    function automatic void compute_expected();
        int         rows, cols, base, i;
        data_word_t v;
        exp_error = 1'b1;
        exp_write = 1'b0;
        exp_clear = 1'b0;
        exp_n     = 0;
        exp_named = (buf_mem[0] == `MIH_NAMED_MARKER);
        exp_name  = '0;
        exp_id    = '0;
        if (exp_named) begin
            if (buf_mem[1] < 1 || buf_mem[1] > `MIH_MAX_ID) return;
            exp_id   = buf_mem[1][2:0];
            exp_name = {buf_mem[2], buf_mem[3]};
            base     = 6;
        end else begin
            base = 2;
        end
        rows = buf_mem[base - 2];
        cols = buf_mem[base - 1];
        if (rows < 1 || rows > int'(settings.max_row)) return;
        if (cols < 1 || cols > int'(settings.max_col)) return;
        if (!exp_named) begin
            for (i = 7; i >= 1; i--) begin
                if (!occupied[i]) exp_id = matrix_id_t'(i);   // Lowest free slot wins
            end
            if (exp_id == '0) return;
        end
        exp_rows  = dim_t'(rows);
        exp_cols  = dim_t'(cols);
        exp_write = 1'b1;
        for (i = 0; i < rows * cols; i++) begin
            v = (base + i < int'(num_count)) ? buf_mem[base + i] : '0;
            if (v < settings.data_min || v > settings.data_max) begin
                exp_clear = 1'b1;
                return;
            end
            exp_elems[exp_n] = v;
            exp_n++;
        end
        exp_error = 1'b0;
    endfunction

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] want);
        if (got !== want) begin
            $display("Mismatch at time %0t: %s is %0h, expected %0h", $time, what, got, want);
            test_errs++;
        end
    endtask

    task automatic load_buffer(input int fill_count);
        int i;
        for (i = 0; i < 2048; i++) begin
            buf_mem[i] = 32'h7000_0000 | i;
        end
        num_count = buf_addr_t'(fill_count);
    endtask

    task automatic put_named(input int id, input int rows, input int cols,
                             input matrix_name_t name);
        buf_mem[0] = `MIH_NAMED_MARKER;
        buf_mem[1] = id;
        buf_mem[2] = name[63:32];
        buf_mem[3] = name[31:0];
        buf_mem[4] = rows;
        buf_mem[5] = cols;
    endtask

    task automatic put_anon(input int rows, input int cols);
        buf_mem[0] = rows;
        buf_mem[1] = cols;
    endtask

    task automatic put_elems(input int first, input int n, input int base);
        int i;
        for (i = 0; i < n; i++) begin
            buf_mem[first + i] = base + i * 29;
        end
    endtask

    task automatic run_test(input string label);
        int cycles, done_base, err_base, i;
        compute_expected();
        test_errs = 0;
        done_base = done_cnt;
        err_base  = err_cnt;
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        compare_value("busy after start", 64'(busy), 64'd1);
        cycles = 0;
        while (done_cnt == done_base && err_cnt == err_base && cycles < 3000) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cycles >= 3000) begin
            $display("Test %0d %s: no done or error pulse within %0d cycles",
                     tests_run + 1, label, cycles);
            test_errs++;
        end else begin
            repeat (4) @(posedge clk);   // Room for a stray second pulse
            #1;
            compare_value("done pulses", 64'(done_cnt - done_base), 64'(!exp_error));
            compare_value("error pulses", 64'(err_cnt - err_base), 64'(exp_error));
            compare_value("write requests", 64'(storage.wr_count), 64'(exp_write));
            compare_value("clear requests", 64'(storage.clr_count), 64'(exp_clear));
            compare_value("elements accepted", 64'(storage.elem_cnt), 64'(exp_n));
            if (exp_write) begin
                compare_value("header named", 64'(storage.hdr_log.named), 64'(exp_named));
                compare_value("header id", 64'(storage.hdr_log.id), 64'(exp_id));
                compare_value("header rows", 64'(storage.hdr_log.rows), 64'(exp_rows));
                compare_value("header cols", 64'(storage.hdr_log.cols), 64'(exp_cols));
                compare_value("header name", storage.hdr_log.name, exp_name);
            end
            if (exp_clear) compare_value("clear id", 64'(storage.clr_id_log), 64'(exp_id));
            for (i = 0; i < exp_n && i < storage.elem_cnt; i++) begin
                compare_value($sformatf("element %0d", i), 64'(storage.elem_log[i]),
                              64'(exp_elems[i]));
            end
            compare_value("busy at end", 64'(busy), 64'd0);
        end
        tests_run++;
        if (test_errs == 0) begin
            $display("Test %0d %s: passed", tests_run, label);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, label, test_errs);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        start        = 1'b0;
        num_count    = '0;
        occupied     = '0;
        settings     = '{max_row: 32'd8, max_col: 32'd8, data_min: -32'sd1000,
                         data_max: 32'sd1000};
        tests_run    = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;

        load_buffer(18);
        put_named(5, 3, 4, "MATRIXAB");
        put_elems(6, 12, -150);
        run_test("named 3x4 with writer stalls");

        load_buffer(6);
        put_anon(2, 2);
        put_elems(2, 4, 300);
        occupied = 8'b0000_0110;   // Slots 1 and 2 taken
        run_test("anonymous into slot 3");

        load_buffer(6);
        put_anon(2, 3);
        put_elems(2, 6, -40);      // Last two lie past the fill count
        occupied = '0;
        run_test("anonymous with zero padding");

        load_buffer(8);
        put_named(0, 2, 2, "ID0WRONG");
        run_test("named with ID 0");

        load_buffer(8);
        put_named(9, 2, 2, "ID9WRONG");
        run_test("named with ID 9");

        load_buffer(8);
        put_anon(3, 0);
        run_test("anonymous with zero cols");

        load_buffer(30);
        put_named(2, 9, 2, "TOOTALL!");
        run_test("named with rows above limit");

        load_buffer(12);
        put_named(4, 2, 3, "CLEARME!");
        put_elems(6, 6, 10);
        buf_mem[9] = 5000;
        run_test("element above data_max");

        load_buffer(6);
        put_anon(2, 2);
        put_elems(2, 4, 1);
        occupied = 8'hFE;
        run_test("anonymous with storage full");

        $display("Tests run %0d, passed %0d, failed %0d", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mih_params.svh ====
`ifndef MIH_PARAMS_SVH
`define MIH_PARAMS_SVH

// Storage layout, one block per matrix slot
`define MIH_SLOT_STRIDE 1152
`define MIH_MAX_ID      7

// Name words in a named record, four ASCII bytes each
`define MIH_NAME_WORDS  2

// Occupancy field in the first word of a storage block
`define MIH_OCC_HI      31
`define MIH_OCC_LO      16

// First word of a named record (-1)
`define MIH_NAMED_MARKER 32'hFFFF_FFFF

`endif

// ==== mih_pkg.sv ====
`default_nettype none
`include "mih_params.svh"

package mih_pkg;

    typedef logic signed [31:0] data_word_t;     // Buffer and storage word
    typedef logic [10:0]        buf_addr_t;
    typedef logic [13:0]        storage_addr_t;
    typedef logic [2:0]         matrix_id_t;
    typedef logic [7:0]         dim_t;
    typedef logic [15:0]        elem_count_t;
    typedef logic [`MIH_NAME_WORDS*32-1:0] matrix_name_t;  // First character in top byte

    typedef struct packed {
        logic         named;
        matrix_id_t   id;
        dim_t         rows;
        dim_t         cols;
        matrix_name_t name;
    } matrix_header_t;

    typedef struct packed {
        logic [31:0]        max_row;
        logic [31:0]        max_col;
        logic signed [31:0] data_min;
        logic signed [31:0] data_max;
    } mih_settings_t;

    typedef enum logic [3:0] {
        S_IDLE, S_PARSE, S_FIND, S_WREQ, S_WRDY, S_STREAM, S_WDONE, S_CLEAR, S_CLWAIT
    } seq_state_t;

    // P_WAIT covers the address cycle of every header word
    typedef enum logic [2:0] {
        P_IDLE, P_MARK, P_WAIT, P_ID, P_NAME, P_ROWS, P_COLS
    } parser_state_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing -j 0 --top-module matrix_input_handler_tb -f compile.f \
    && ./obj_dir/Vmatrix_input_handler_tb | tee /dev/stderr | grep -q "^RESULT: PASS$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== storage_manager_model.sv ====
`default_nettype none
`include "mih_params.svh"

module storage_manager_model (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic [7:0]              occupied,
    input  mih_pkg::storage_addr_t  storage_rd_addr,
    output mih_pkg::data_word_t     storage_rd_data,
    input  logic                    write_request,
    output logic                    write_ready,
    output logic                    writer_ready,
    output logic                    write_done,
    input  mih_pkg::matrix_header_t header,
    input  mih_pkg::data_word_t     data_in,
    input  logic                    data_valid,
    input  logic                    clear_request,
    input  mih_pkg::matrix_id_t     clear_matrix_id,
    output logic                    clear_done
);
    import mih_pkg::*;

    typedef enum logic [1:0] {M_IDLE, M_DATA, M_FINISH, M_CLEAR} model_state_t;

    model_state_t   mstate;
    logic [31:0]    rng;
    int             wait_cnt;
    int             expect_n;
    // Log of the last record, read by the testbench
    int             wr_count;
    int             clr_count;
    int             elem_cnt;
    matrix_header_t hdr_log;
    matrix_id_t     clr_id_log;
    data_word_t     elem_log [0:255];

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        int           slot;
        logic         rdy_n;
        logic         wdone_n;
        logic         cdone_n;
        data_word_t   rd_n;
        model_state_t nxt;
        if (!rst_n) begin
            mstate          <= M_IDLE;
            rng             <= 32'h35f3;
            wait_cnt        <= 0;
            expect_n        <= 0;
            wr_count        <= 0;
            clr_count       <= 0;
            elem_cnt        <= 0;
            write_ready     <= 1'b1;
            writer_ready    <= 1'b0;
            write_done      <= 1'b0;
            clear_done      <= 1'b0;
            storage_rd_data <= '0;
        end else begin
            rng     <= xorshift32(rng);
            slot    = int'(storage_rd_addr) / `MIH_SLOT_STRIDE;
            rd_n    = (slot < 8 && occupied[slot[2:0]]) ? 32'h0001_0000 : '0;  // Occupancy field
            nxt     = mstate;
            rdy_n   = 1'b0;
            wdone_n = 1'b0;
            cdone_n = 1'b0;
            if (start) begin
                wr_count  <= 0;
                clr_count <= 0;
                elem_cnt  <= 0;
            end
            case (mstate)
                M_IDLE: begin
                    if (write_request) begin
                        wr_count <= wr_count + 1;
                        hdr_log  <= header;
                        expect_n <= int'(header.rows) * int'(header.cols);
                        nxt      = M_DATA;
                    end
                end
                M_DATA: begin
                    rdy_n = (rng[1:0] != 2'b00);   // Random stalls
                    if (data_valid) begin
                        elem_log[elem_cnt] <= data_in;
                        elem_cnt           <= elem_cnt + 1;
                        if (elem_cnt + 1 == expect_n) begin
                            rdy_n    = 1'b0;
                            wait_cnt <= 3;
                            nxt      = M_FINISH;
                        end
                    end
                end
                M_FINISH, M_CLEAR: begin
                    if (wait_cnt == 0) begin
                        wdone_n = (mstate == M_FINISH);
                        cdone_n = (mstate == M_CLEAR);
                        nxt     = M_IDLE;
                    end else begin
                        wait_cnt <= wait_cnt - 1;
                    end
                end
            endcase
            // A clear ends any write in progress
            if (clear_request) begin
                clr_count  <= clr_count + 1;
                clr_id_log <= clear_matrix_id;
                wait_cnt   <= 2;
                rdy_n      = 1'b0;
                nxt        = M_CLEAR;
            end
            mstate          <= nxt;
            write_ready     <= #1 (nxt == M_IDLE);
            writer_ready    <= #1 rdy_n;
            write_done      <= #1 wdone_n;
            clear_done      <= #1 cdone_n;
            storage_rd_data <= #1 rd_n;
        end
    end

endmodule

`default_nettype wire
